//--- Makefile
# Verilator build and run for the processor testbench

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --assert --top-module procTb -f src.f
	@out="$$(./obj_dir/VprocTb)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf obj_dir

//--- hdl/control.sv
/*
 * Control unit
 * Opcode decoder into the control word, run/exception/halted sequencer,
 * illegal opcode and stray RTI trapping
 */
`timescale 1ns/1ns
module control (
   input  logic           clk,
   input  logic           rst,
   input  logic [4:0]     opcode,
   input  logic [1:0]     funct,
   output procPkg::ctrl_t ctrl,
   output logic           run,
   output logic           halted,
   output logic           err
);
   import procPkg::*;

   typedef enum logic [1:0] {Running, Exception, Halted} state_t;

   state_t state;
   logic   haltOp;
   logic   illegal;
   logic   stop;

   always_comb begin
      // Defaults give a NOP
      ctrl            = '0;
      ctrl.destSel    = DestRt;
      ctrl.aluOp      = AluAdd;
      ctrl.aluSrcImm  = 1'b1;
      ctrl.immSel     = ImmS5;
      ctrl.wbSel      = WbAlu;
      ctrl.branchCond = opcode[1:0];
      ctrl.pcSel      = PcPlus2;
      haltOp          = 1'b0;
      illegal         = 1'b0;
      case (opcode)
         OpHalt:  haltOp = 1'b1;
         OpNop:   ;
         OpAddi:  ctrl.regWrite = 1'b1;
         OpSubi: begin
            ctrl.regWrite = 1'b1;
            ctrl.aluOp    = AluSub;
         end
         OpXori, OpAndni: begin
            ctrl.regWrite = 1'b1;
            ctrl.aluOp    = (opcode == OpXori) ? AluXor : AluAndn;
            ctrl.immSel   = ImmZ5; // Logic ops zero-extend
         end
         OpSt: begin
            ctrl.memEnable = 1'b1;
            ctrl.memWrite  = 1'b1;
         end
         OpLd: begin
            ctrl.regWrite  = 1'b1;
            ctrl.memEnable = 1'b1;
            ctrl.wbSel     = WbMem;
         end
         OpRform: begin
            ctrl.regWrite  = 1'b1;
            ctrl.destSel   = DestRd;
            ctrl.aluSrcImm = 1'b0;
            case (funct)
               2'b00:   ctrl.aluOp = AluAdd;
               2'b01:   ctrl.aluOp = AluSub;
               2'b10:   ctrl.aluOp = AluXor;
               default: ctrl.aluOp = AluAndn;
            endcase
         end
         OpLbi, OpSlbi: begin
            ctrl.regWrite = 1'b1;
            ctrl.destSel  = DestRs;
            ctrl.aluOp    = (opcode == OpLbi) ? AluPassB : AluSlbi;
            ctrl.immSel   = (opcode == OpLbi) ? ImmS8 : ImmZ8;
         end
         OpBeqz, OpBnez, OpBltz: begin
            ctrl.branch = 1'b1;
            ctrl.immSel = ImmS8;
            ctrl.pcSel  = PcBranch;
         end
         OpJ: begin
            ctrl.immSel = ImmS11;
            ctrl.pcSel  = PcJump;
         end
         OpJr: begin
            ctrl.immSel = ImmS8;
            ctrl.pcSel  = PcReg;
         end
         OpJal: begin
            ctrl.regWrite = 1'b1;
            ctrl.destSel  = DestR7;
            ctrl.wbSel    = WbLink;
            ctrl.immSel   = ImmS11;
            ctrl.pcSel    = PcJump;
         end
         OpSiic:  ctrl.pcSel = PcTrap;
         OpRti: begin
            ctrl.pcSel = PcReturn;
            illegal    = (state != Exception); // Nothing to return from
         end
         default: illegal = 1'b1;
      endcase
   end

   // Halt and errors retire nothing
   assign stop   = haltOp || illegal;
   assign run    = (state != Halted) && !stop;
   assign err    = illegal;
   assign halted = (state == Halted);

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= Running;
      end else begin
         case (state)
            Running, Exception: begin
               if (stop) begin
                  state <= Halted;
               end else if (ctrl.pcSel == PcTrap) begin
                  state <= Exception;
               end else if (ctrl.pcSel == PcReturn) begin
                  state <= Running;
               end
            end
            default: state <= Halted; // Only reset leaves
         endcase
      end
   end

   errHalts: assert property (@(posedge clk) disable iff (rst) err |=> halted);

endmodule

//--- hdl/decode.sv
/*
 * Decode and writeback
 * Register file, immediate extension, writeback mux and retirement record
 */
`timescale 1ns/1ns
module decode (
   input  logic                          clk,
   input  logic [procPkg::DataWidth-1:0] instr,
   input  procPkg::ctrl_t                ctrl,
   input  logic                          run,
   input  logic [procPkg::DataWidth-1:0] pc,
   input  logic [procPkg::DataWidth-1:0] aluOut,
   input  logic [procPkg::DataWidth-1:0] memOut,
   output logic [procPkg::DataWidth-1:0] rsVal,
   output logic [procPkg::DataWidth-1:0] rtVal,
   output logic [procPkg::DataWidth-1:0] imm,
   output procPkg::trace_t               wrTrace
);
   import procPkg::*;

   logic [DataWidth-1:0]    regs [RegCount]; // r0 is an ordinary register
   logic [RegAddrWidth-1:0] rs, rt, rd;
   logic [RegAddrWidth-1:0] dest;
   logic [DataWidth-1:0]    wbVal;
   logic                    wrEn;

   assign rs = instr[10:8];
   assign rt = instr[7:5];
   assign rd = instr[4:2]; // R-format only

   assign rsVal = regs[rs];
   assign rtVal = regs[rt]; // Also store data

   // Immediate forms
   always_comb begin
      case (ctrl.immSel)
         ImmZ5:   imm = {11'b0, instr[4:0]};
         ImmS8:   imm = {{8{instr[7]}}, instr[7:0]};
         ImmZ8:   imm = {8'b0, instr[7:0]};
         ImmS11:  imm = {{5{instr[10]}}, instr[10:0]};
         default: imm = {{11{instr[4]}}, instr[4:0]};
      endcase
   end

   always_comb begin
      case (ctrl.destSel)
         DestRd:  dest = rd;
         DestRs:  dest = rs;      // LBI, SLBI
         DestR7:  dest = 3'd7;    // JAL link
         default: dest = rt;
      endcase
   end

   always_comb begin
      case (ctrl.wbSel)
         WbMem:   wbVal = memOut;
         WbLink:  wbVal = pc + 16'd2;
         default: wbVal = aluOut;
      endcase
   end

   assign wrEn = run && ctrl.regWrite;

   always_ff @(posedge clk) begin
      if (wrEn) begin
         regs[dest] <= wbVal;
      end
   end

   // Same-cycle view of the write above
   assign wrTrace.valid  = wrEn;
   assign wrTrace.regNum = dest;
   assign wrTrace.value  = wbVal;
   assign wrTrace.pc     = pc;

endmodule

//--- hdl/execute.sv
/*
 * Execute stage
 * ALU for the arithmetic and logic ops, branch flags on rs
 */
`timescale 1ns/1ns
module execute (
   input  procPkg::ctrl_t                ctrl,
   input  logic [procPkg::DataWidth-1:0] rsVal,
   input  logic [procPkg::DataWidth-1:0] rtVal,
   input  logic [procPkg::DataWidth-1:0] imm,
   output logic [procPkg::DataWidth-1:0] aluOut,
   output logic                          taken
);
   import procPkg::*;

   logic [DataWidth-1:0] opA;
   logic [DataWidth-1:0] opB;
   logic                 zero;
   logic                 sign;
   logic                 condMet;

   assign opA = rsVal;
   assign opB = ctrl.aluSrcImm ? imm : rtVal;

   always_comb begin
      case (ctrl.aluOp)
         AluSub:   aluOut = opB - opA;  // ISA subtracts rs from B
         AluXor:   aluOut = opA ^ opB;
         AluAndn:  aluOut = opA & ~opB;
         AluPassB: aluOut = opB;        // LBI
         AluSlbi:  aluOut = {opA[7:0], 8'b0} | opB;
         default:  aluOut = opA + opB;  // Also address calc for LD/ST
      endcase
   end

   // Flags come from rs, not the ALU result
   assign zero = (rsVal == '0);
   assign sign = rsVal[DataWidth-1];

   always_comb begin
      case (ctrl.branchCond)
         OpBeqz[1:0]: condMet = zero;
         OpBnez[1:0]: condMet = !zero;
         OpBltz[1:0]: condMet = sign;
         default:     condMet = 1'b0; // BGEZ not supported
      endcase
   end

   assign taken = ctrl.branch && condMet;

endmodule

//--- hdl/fetch.sv
/*
 * Fetch stage
 * PC and exception PC registers, next-PC mux, writable instruction memory
 */
`timescale 1ns/1ns
module fetch (
   input  logic                                clk,
   input  logic                                rst,
   input  procPkg::ctrl_t                      ctrl,
   input  logic                                run,
   input  logic                                taken,
   input  logic [procPkg::DataWidth-1:0]       imm,
   input  logic [procPkg::DataWidth-1:0]       rsVal,
   input  logic                                imemWe,
   input  logic [procPkg::ImemAddrWidth-1:0]   imemAddr,
   input  logic [procPkg::DataWidth-1:0]       imemData,
   output logic [procPkg::DataWidth-1:0]       instr,
   output logic [procPkg::DataWidth-1:0]       pc
);
   import procPkg::*;

   logic [DataWidth-1:0] imem [ImemDepth];
   logic [DataWidth-1:0] epc;      // Return address for RTI
   logic [DataWidth-1:0] pcPlus2;
   logic [DataWidth-1:0] nextPc;

   assign pcPlus2 = pc + 16'd2;
   assign instr   = imem[pc[ImemAddrWidth:1]]; // Word index

   always_comb begin
      case (ctrl.pcSel)
         PcBranch: nextPc = taken ? pcPlus2 + imm : pcPlus2;
         PcJump:   nextPc = pcPlus2 + imm; // J and JAL
         PcReg:    nextPc = rsVal + imm;   // JR
         PcTrap:   nextPc = TrapVector;
         PcReturn: nextPc = epc;
         default:  nextPc = pcPlus2;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         pc <= '0;
      end else if (run) begin
         pc <= nextPc; // Holds once halted
      end
   end

   always_ff @(posedge clk) begin
      if (run && ctrl.pcSel == PcTrap) begin
         epc <= pcPlus2; // Resume after the SIIC
      end
   end

   // Loader port, used while the core sits in reset
   always_ff @(posedge clk) begin
      if (imemWe) begin
         imem[imemAddr] <= imemData;
      end
   end

   // Odd displacements or register targets would land here
   pcEven: assert property (@(posedge clk) disable iff (rst) !pc[0]);

endmodule

//--- hdl/memory.sv
/*
 * Data memory
 * Word-addressed, combinational read, write on the clock edge
 */
`timescale 1ns/1ns
module memory (
   input  logic                          clk,
   input  procPkg::ctrl_t                ctrl,
   input  logic                          run,
   input  logic [procPkg::DataWidth-1:0] addr,
   input  logic [procPkg::DataWidth-1:0] wrData,
   output logic [procPkg::DataWidth-1:0] rdData
);
   import procPkg::*;

   logic [DataWidth-1:0]     mem [DmemDepth];
   logic [DmemAddrWidth-1:0] wordAddr;

   assign wordAddr = addr[DmemAddrWidth:1]; // Byte address to word index
   assign rdData   = mem[wordAddr];

   always_ff @(posedge clk) begin
      if (run && ctrl.memEnable && ctrl.memWrite) begin
         mem[wordAddr] <= wrData;
      end
   end

   // rs plus offset must stay word aligned
   alignedAccess: assert property (@(posedge clk)
      (run && ctrl.memEnable) |-> !addr[0]);

endmodule

//--- hdl/proc.sv
/*
 * Single-cycle 16-bit processor top level
 * Fetch, control, decode, execute and data memory, one instruction per clock
 */
`timescale 1ns/1ns
module proc (
   input  logic                              clk,
   input  logic                              rst,
   input  logic                              imemWe,
   input  logic [procPkg::ImemAddrWidth-1:0] imemAddr,
   input  logic [procPkg::DataWidth-1:0]     imemData,
   output logic                              err,
   output logic                              halted,
   output procPkg::trace_t                   trace
);
   import procPkg::*;

   ctrl_t                ctrl;
   logic                 run;     // Write enable for every stage
   logic                 taken;
   logic [DataWidth-1:0] instr, pc;
   logic [DataWidth-1:0] rsVal, rtVal, imm;
   logic [DataWidth-1:0] aluOut, memOut;

   fetch fetchInst (
      .clk(clk), .rst(rst), .ctrl(ctrl), .run(run), .taken(taken),
      .imm(imm), .rsVal(rsVal),
      .imemWe(imemWe), .imemAddr(imemAddr), .imemData(imemData),
      .instr(instr), .pc(pc)
   );

   control controlInst (
      .clk(clk), .rst(rst), .opcode(instr[15:11]), .funct(instr[1:0]),
      .ctrl(ctrl), .run(run), .halted(halted), .err(err)
   );

   decode decodeInst (
      .clk(clk), .instr(instr), .ctrl(ctrl), .run(run), .pc(pc),
      .aluOut(aluOut), .memOut(memOut),
      .rsVal(rsVal), .rtVal(rtVal), .imm(imm),
      .wrTrace(trace) // Retirement record straight out
   );

   execute executeInst (
      .ctrl(ctrl), .rsVal(rsVal), .rtVal(rtVal), .imm(imm),
      .aluOut(aluOut), .taken(taken)
   );

   memory memoryInst (
      .clk(clk), .ctrl(ctrl), .run(run),
      .addr(aluOut), .wrData(rtVal), // Store data from instr[7:5]
      .rdData(memOut)
   );

endmodule

//--- hdl/procPkg.sv
/*
 * Shared definitions for the 16-bit single-cycle processor
 * Widths, opcode encodings, control word and retirement record
 */
package procPkg;

   localparam int DataWidth     = 16;
   localparam int RegCount      = 8;
   localparam int RegAddrWidth  = 3;
   localparam int ImemDepth     = 256; // Words
   localparam int DmemDepth     = 256;
   localparam int ImemAddrWidth = 8;
   localparam int DmemAddrWidth = 8;
   localparam logic [DataWidth-1:0] TrapVector = 16'h0002; // SIIC handler

   // Opcodes, instr[15:11]
   localparam logic [4:0] OpHalt  = 5'b00000;
   localparam logic [4:0] OpNop   = 5'b00001;
   localparam logic [4:0] OpSiic  = 5'b00010;
   localparam logic [4:0] OpRti   = 5'b00011;
   localparam logic [4:0] OpJ     = 5'b00100;
   localparam logic [4:0] OpJr    = 5'b00101;
   localparam logic [4:0] OpJal   = 5'b00110;
   localparam logic [4:0] OpAddi  = 5'b01000;
   localparam logic [4:0] OpSubi  = 5'b01001;
   localparam logic [4:0] OpXori  = 5'b01010;
   localparam logic [4:0] OpAndni = 5'b01011;
   localparam logic [4:0] OpBeqz  = 5'b01100; // Low two bits double as branch condition
   localparam logic [4:0] OpBnez  = 5'b01101;
   localparam logic [4:0] OpBltz  = 5'b01110;
   localparam logic [4:0] OpSt    = 5'b10000;
   localparam logic [4:0] OpLd    = 5'b10001;
   localparam logic [4:0] OpSlbi  = 5'b10010;
   localparam logic [4:0] OpLbi   = 5'b11000;
   localparam logic [4:0] OpRform = 5'b11011; // add/sub/xor/andn by funct

   typedef enum logic [2:0] {AluAdd, AluSub, AluXor, AluAndn, AluPassB, AluSlbi} aluOp_t;
   typedef enum logic [2:0] {ImmS5, ImmZ5, ImmS8, ImmZ8, ImmS11} immSel_t;
   typedef enum logic [2:0] {PcPlus2, PcBranch, PcJump, PcReg, PcTrap, PcReturn} pcSel_t;
   typedef enum logic [1:0] {WbAlu, WbMem, WbLink} wbSel_t;
   // Destination field: instr[4:2], instr[7:5], instr[10:8] or r7
   typedef enum logic [1:0] {DestRd, DestRt, DestRs, DestR7} destSel_t;

   typedef struct packed {
      logic     regWrite;
      destSel_t destSel;
      aluOp_t   aluOp;
      logic     aluSrcImm;  // B operand is immediate
      immSel_t  immSel;
      logic     memEnable;
      logic     memWrite;
      wbSel_t   wbSel;
      logic     branch;
      logic [1:0] branchCond; // Matches Op*[1:0] of the branch opcodes
      pcSel_t   pcSel;
   } ctrl_t;

   // One record per register write
   typedef struct packed {
      logic                    valid;
      logic [RegAddrWidth-1:0] regNum;
      logic [DataWidth-1:0]    value;
      logic [DataWidth-1:0]    pc;
   } trace_t;

endpackage

//--- sim/clockGen.sv
/*
 * Testbench clock source
 * Free-running clock, 40 ns period, starts low
 */
`timescale 1ns/1ns
module clockGen (
   output logic clk
);
   localparam int HalfPeriod = 20; // ns

   initial begin
      clk = 1'b0;
      forever #HalfPeriod clk = ~clk;
   end

endmodule

//--- sim/procCases.txt
// Case count, then per case: program length, program words,
// write count, (register, value) pairs, expected err bit
0006
// Immediate and register add, sub, xor, andn
000B C105 C213 417D 4981 52BF 5AC3 D95C D941 DA8E DC37 0000
000A 0001 0005 0002 0013 0003 0002 0004 FFFC 0005 000C
0006 0010 0007 0018 0000 000E 0003 FFEF 0005 FFF8
0000
// LBI plus SLBI constant, store then load back
0009 C112 91AB C280 C320 8322 835E 8B82 8BBE 0000
0006 0001 0012 0001 12AB 0002 FF80 0003 0020 0004 12AB 0005 FF80
0000
// Branches taken and not taken, J, JAL, JR
0012 C100 C2FF 6102 C311 6902 C322 7202 C333 2002
C344 3002 C355 C41E 2C02 C366 C377 C55A 0000
0006 0001 0000 0002 FFFF 0003 0022 0007 0016 0004 001E 0005 005A
0000
// SIIC into handler at 2, RTI back after the SIIC
0007 2004 C666 1800 C101 1000 C202 0000
0003 0001 0001 0006 0066 0002 0002
0000
// Illegal opcode halts with err
0003 C107 F800 C201
0001 0001 0007
0001
// RTI outside an exception halts with err
0003 C109 1800 C201
0001 0001 0009
0001

//--- sim/procTb.sv
/*
 * Testbench for the single-cycle processor
 * Loads each program from the case file, checks the register-write trace,
 * the halt state and the error flag
 */
`timescale 1ns/1ns
module procTb;
   import procPkg::*;

   localparam int CaseWords   = 512;  // Case file capacity
   localparam int MaxCases    = 64;
   localparam int ResetCycles = 16;
   localparam int HaltTimeout = 2000; // Cycles per case
   localparam int WatchCycles = 4;    // Quiet cycles checked after halt
   localparam int DriveDelay  = 2;    // ns after the rising edge

   logic                     clk;
   logic                     rst;
   logic                     imemWe;
   logic [ImemAddrWidth-1:0] imemAddr;
   logic [DataWidth-1:0]     imemData;
   logic                     err;
   logic                     halted;
   trace_t                   trace;

   logic [DataWidth-1:0] caseMem [CaseWords]; // Raw case file words
   int                   rdPtr;               // Next unread word
   int                   errorCount;
   int                   timeoutCount;

   clockGen clockGenInst (
      .clk(clk)
   );

   proc proc_inst (
      .clk(clk), .rst(rst),
      .imemWe(imemWe), .imemAddr(imemAddr), .imemData(imemData),
      .err(err), .halted(halted), .trace(trace)
   );

   // Register an instruction word writes under the ISA, -1 if none
   function automatic int writtenReg(input logic [DataWidth-1:0] word);
      case (word[15:11])
         OpAddi, OpSubi, OpXori, OpAndni, OpLd: return int'(word[7:5]); // rt
         OpRform:       return int'(word[4:2]);  // rd
         OpLbi, OpSlbi: return int'(word[10:8]); // rs
         OpJal:         return 7;                // Link register
         default:       return -1;
      endcase
   endfunction

   // Hold reset at least 16 edges, writing one program word per edge
   task automatic resetAndLoad(input int progLen, input int progBase);
      int cycle;
      int total;
      total = (progLen > ResetCycles) ? progLen : ResetCycles;
      @(posedge clk);
      #DriveDelay;
      rst = 1'b1;
      for (cycle = 0; cycle < total; cycle++) begin
         if (cycle < progLen) begin
            imemWe   = 1'b1;
            imemAddr = cycle[ImemAddrWidth-1:0];
            imemData = caseMem[progBase + cycle];
         end else begin
            imemWe = 1'b0;
         end
         @(posedge clk);
         #DriveDelay;
      end
      imemWe = 1'b0;
      rst    = 1'b0; // First instruction retires on the next edge
   endtask

   // One retired write against the idx-th expected pair and the program
   task automatic checkWrite(input int caseNum, input int idx, input int pairBase,
                             input int progBase, input int progLen);
      logic [RegAddrWidth-1:0] expReg;
      logic [DataWidth-1:0]    expVal;
      int                      wordIdx;
      int                      pcReg;
      expReg  = caseMem[pairBase + 2 * idx][RegAddrWidth-1:0];
      expVal  = caseMem[pairBase + 2 * idx + 1];
      wordIdx = int'(trace.pc[DataWidth-1:1]);
      pcReg   = (wordIdx < progLen) ? writtenReg(caseMem[progBase + wordIdx]) : -1;
      if (trace.regNum !== expReg) begin
         $display("ERROR at %0t: case %0d write %0d trace.regNum got %0d expected %0d",
                  $time, caseNum, idx, trace.regNum, expReg);
         errorCount++;
      end
      if (trace.value !== expVal) begin
         $display("ERROR at %0t: case %0d write %0d trace.value got %h expected %h",
                  $time, caseNum, idx, trace.value, expVal);
         errorCount++;
      end
      // Word at trace.pc has to be the instruction writing that register
      if (trace.pc[0] !== 1'b0 || pcReg != int'(expReg)) begin
         $display("ERROR at %0t: case %0d write %0d trace.pc %h writes r%0d expected r%0d",
                  $time, caseNum, idx, trace.pc, pcReg, expReg);
         errorCount++;
      end
   endtask

   // After halt, state must stick and nothing may retire
   task automatic watchAfterHalt(input int caseNum);
      int k;
      for (k = 0; k < WatchCycles; k++) begin
         @(negedge clk);
         if (halted !== 1'b1) begin
            $display("ERROR at %0t: case %0d halted got %b expected 1",
                     $time, caseNum, halted);
            errorCount++;
         end
         if (trace.valid !== 1'b0) begin
            $display("ERROR at %0t: case %0d trace.valid got %b expected 0",
                     $time, caseNum, trace.valid);
            errorCount++;
         end
      end
   endtask

   task automatic runCase(input int caseNum);
      int   progLen;
      int   progBase;
      int   expCount;
      int   pairBase;
      int   seen;
      int   cycles;
      logic expErr;
      logic done;
      progLen  = int'(caseMem[rdPtr]);
      progBase = rdPtr + 1;
      expCount = int'(caseMem[progBase + progLen]);
      pairBase = progBase + progLen + 1;
      expErr   = caseMem[pairBase + 2 * expCount][0];
      rdPtr    = pairBase + 2 * expCount + 1; // Start of next case
      resetAndLoad(progLen, progBase);
      seen = 0;
      done = 1'b0;
      // Sample mid-cycle, away from both drive and clock edges
      for (cycles = 0; cycles < HaltTimeout && !done; cycles++) begin
         @(negedge clk);
         if (halted === 1'b1) begin
            done = 1'b1;
         end else if (trace.valid === 1'b1) begin
            if (seen < expCount) begin
               checkWrite(caseNum, seen, pairBase, progBase, progLen);
            end
            seen++;
         end
      end
      if (!done) begin
         $display("Case %0d hung: halted never rose within %0d cycles",
                  caseNum, HaltTimeout);
         timeoutCount++;
      end else begin
         if (seen != expCount) begin
            $display("ERROR at %0t: case %0d trace.valid count got %0d expected %0d",
                     $time, caseNum, seen, expCount);
            errorCount++;
         end
         if (err !== expErr) begin
            $display("ERROR at %0t: case %0d err got %b expected %b",
                     $time, caseNum, err, expErr);
            errorCount++;
         end
         watchAfterHalt(caseNum);
      end
   endtask

   initial begin
      int caseCount;
      int c;
      rst          = 1'b1;
      imemWe       = 1'b0;
      imemAddr     = '0;
      imemData     = '0;
      errorCount   = 0;
      timeoutCount = 0;
      $readmemh("sim/procCases.txt", caseMem);
      caseCount = int'(caseMem[0]);
      rdPtr     = 1;
      if (caseCount < 1 || caseCount > MaxCases) begin
         $display("Case file sim/procCases.txt holds no usable case count");
         errorCount++;
      end else begin
         for (c = 1; c <= caseCount; c++) begin
            runCase(c);
         end
      end
      $display("Cases done with %0d errors and %0d timeouts", errorCount, timeoutCount);
      if (errorCount == 0 && timeoutCount == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

//--- src.f
hdl/procPkg.sv
hdl/fetch.sv
hdl/control.sv
hdl/decode.sv
hdl/execute.sv
hdl/memory.sv
hdl/proc.sv
sim/clockGen.sv
sim/procTb.sv
